/* common/wisc_consts.svh */
`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

// Datapath word
`define DATA_W 16

// Instruction fields
`define OP_W 5
`define FUNCT_W 2

// Rotates and shifts use the low bits of operand B
`define SHAMT_W 4

`endif

/* common/isa_pkg.sv */
`default_nettype none

`include "wisc_consts.svh"

package isa_pkg;

  typedef enum logic [`OP_W-1:0] {
    OP_HALT  = 5'b00000,
    OP_ADDI  = 5'b01000,
    OP_SUBI  = 5'b01001,
    OP_XORI  = 5'b01010,
    OP_ANDNI = 5'b01011,
    OP_BLTZ  = 5'b01110,
    OP_BGEZ  = 5'b01111,
    OP_ST    = 5'b10000,
    OP_LD    = 5'b10001,
    OP_SLBI  = 5'b10010,
    OP_STU   = 5'b10011,
    OP_ROLI  = 5'b10100,
    OP_SLLI  = 5'b10101,
    OP_RORI  = 5'b10110,
    OP_SRLI  = 5'b10111,
    OP_LBI   = 5'b11000,
    OP_BTR   = 5'b11001,
    OP_ROL   = 5'b11010, // ROL, SLL, ROR, SRL by funct
    OP_RRR   = 5'b11011, // ADD, SUB, XOR, ANDN by funct
    OP_SEQ   = 5'b11100,
    OP_SLT   = 5'b11101,
    OP_SLE   = 5'b11110,
    OP_SCO   = 5'b11111
  } opcode_e;

  // Function field in the register-register groups
  //   RRR group 00 ADD, 01 SUB, 10 XOR, 11 ANDN
  //   ROL group 00 ROL, 01 SLL, 10 ROR, 11 SRL

  typedef struct packed {
    opcode_e                opcode;
    logic [`FUNCT_W-1:0]    funct;
  } instr_t;

endpackage

`default_nettype wire

/* common/exec_pkg.sv */
`default_nettype none

`include "wisc_consts.svh"

package exec_pkg;

  // Low two bits pick the shift when the top bit is clear
  typedef enum logic [2:0] {
    ALU_ROL = 3'b000,
    ALU_SLL = 3'b001,
    ALU_ROR = 3'b010,
    ALU_SRL = 3'b011,
    ALU_ADD = 3'b100,
    ALU_OR  = 3'b101,
    ALU_XOR = 3'b110,
    ALU_AND = 3'b111
  } alu_op_e;

  typedef struct packed {
    logic    inv_a;
    logic    inv_b;
    logic    sign;   // Signed overflow reporting
    logic    cin;
    logic    pass_b; // Result is operand B as is
    alu_op_e op;
  } alu_ctrl_t;

  // Stage 1 payload
  typedef struct packed {
    isa_pkg::instr_t      instr;
    alu_ctrl_t            ctrl;
    logic [`DATA_W-1:0]   operand_a;
    logic [`DATA_W-1:0]   operand_b;
  } issue_t;

  // Stage 2 payload and stage output
  typedef struct packed {
    logic [`DATA_W-1:0]   word;
    logic                 branch_taken;
    logic                 halt;
  } exec_result_t;

endpackage

`default_nettype wire

/* alu/shifter.sv */
`default_nettype none

`include "wisc_consts.svh"

module shifter (
  input  logic [`DATA_W-1:0]    value,
  input  logic [`SHAMT_W-1:0]   shamt,
  input  exec_pkg::alu_op_e     op,
  output logic [`DATA_W-1:0]    shifted
);

  logic [2*`DATA_W-1:0] doubled;
  logic [2*`DATA_W-1:0] rol_wide;
  logic [2*`DATA_W-1:0] ror_wide;

  // Rotates come out of a doubled copy of the value
  assign doubled = {value, value};
  assign rol_wide = doubled << shamt;
  assign ror_wide = doubled >> shamt;

  always_comb
  begin
    case (op[1:0])
      2'b00: shifted = rol_wide[2*`DATA_W-1:`DATA_W];
      2'b01: shifted = value << shamt;  // Zero fill
      2'b10: shifted = ror_wide[`DATA_W-1:0];
      default: shifted = value >> shamt;
    endcase
  end

endmodule

`default_nettype wire

/* alu/alu.sv */
`default_nettype none

`include "wisc_consts.svh"

module alu (
  input  logic [`DATA_W-1:0]    a,
  input  logic [`DATA_W-1:0]    b,
  input  exec_pkg::alu_ctrl_t   ctrl,
  output logic [`DATA_W-1:0]    result,
  output logic                  carry_out,
  output logic                  overflow
);

  logic [`DATA_W-1:0] a_op;
  logic [`DATA_W-1:0] b_op;
  logic [`DATA_W:0]   sum_wide;
  logic [`DATA_W-1:0] shifted;
  logic [`DATA_W-1:0] op_result;
  logic               signed_ovf;

  assign a_op = ctrl.inv_a ? ~a : a;
  assign b_op = ctrl.inv_b ? ~b : b;

  assign sum_wide = {1'b0, a_op} + {1'b0, b_op} + {{`DATA_W{1'b0}}, ctrl.cin};
  assign carry_out = sum_wide[`DATA_W];

  // Same-sign inputs with a sum of the other sign
  assign signed_ovf = (a_op[`DATA_W-1] == b_op[`DATA_W-1]) &&
                      (sum_wide[`DATA_W-1] != a_op[`DATA_W-1]);
  assign overflow = ctrl.sign ? signed_ovf : carry_out;

  shifter i_shifter (
    .value   (a_op),
    .shamt   (b[`SHAMT_W-1:0]),
    .op      (ctrl.op),
    .shifted (shifted)
  );

  always_comb
  begin
    case (ctrl.op)
      exec_pkg::ALU_ADD: op_result = sum_wide[`DATA_W-1:0];
      exec_pkg::ALU_OR:  op_result = a_op | b_op;
      exec_pkg::ALU_XOR: op_result = a_op ^ b_op;
      exec_pkg::ALU_AND: op_result = a_op & b_op;
      default:           op_result = shifted;
    endcase
  end

  assign result = ctrl.pass_b ? b : op_result; // LBI

endmodule

`default_nettype wire

/* src/alu_control.sv */
`default_nettype none

module alu_control (
  input  isa_pkg::instr_t      instr,
  output exec_pkg::alu_ctrl_t  ctrl
);

  always_comb
  begin
    ctrl = '0;
    ctrl.op = exec_pkg::ALU_ROL; // HALT and undefined opcodes
    case (instr.opcode)
      isa_pkg::OP_LBI:
      begin
        ctrl.pass_b = 1'b1;
      end
      isa_pkg::OP_RRR:
      begin
        case (instr.funct)
          2'b00: ctrl.op = exec_pkg::ALU_ADD;
          2'b01:
          begin
            ctrl.inv_a = 1'b1; // B - A
            ctrl.cin = 1'b1;
            ctrl.op = exec_pkg::ALU_ADD;
          end
          2'b10: ctrl.op = exec_pkg::ALU_XOR;
          default:
          begin
            ctrl.inv_b = 1'b1; // ANDN
            ctrl.op = exec_pkg::ALU_AND;
          end
        endcase
      end
      isa_pkg::OP_ROL:
      begin
        case (instr.funct)
          2'b00: ctrl.op = exec_pkg::ALU_ROL;
          2'b01: ctrl.op = exec_pkg::ALU_SLL;
          2'b10: ctrl.op = exec_pkg::ALU_ROR;
          default: ctrl.op = exec_pkg::ALU_SRL;
        endcase
      end
      isa_pkg::OP_SEQ,
      isa_pkg::OP_SUBI:
      begin
        ctrl.inv_a = 1'b1;
        ctrl.cin = 1'b1;
        ctrl.op = exec_pkg::ALU_ADD;
      end
      // A - B with signed overflow for compares and branches
      isa_pkg::OP_SLT,
      isa_pkg::OP_SLE,
      isa_pkg::OP_BLTZ,
      isa_pkg::OP_BGEZ:
      begin
        ctrl.sign = 1'b1;
        ctrl.inv_b = 1'b1;
        ctrl.cin = 1'b1;
        ctrl.op = exec_pkg::ALU_ADD;
      end
      isa_pkg::OP_ADDI:
      begin
        ctrl.sign = 1'b1;
        ctrl.op = exec_pkg::ALU_ADD;
      end
      isa_pkg::OP_SCO,
      isa_pkg::OP_ST,
      isa_pkg::OP_LD,
      isa_pkg::OP_STU,
      isa_pkg::OP_BTR:
      begin
        ctrl.op = exec_pkg::ALU_ADD; // Address add
      end
      isa_pkg::OP_SLBI:
      begin
        ctrl.op = exec_pkg::ALU_OR; // A arrives pre-shifted
      end
      isa_pkg::OP_XORI:
      begin
        ctrl.op = exec_pkg::ALU_XOR;
      end
      isa_pkg::OP_ANDNI:
      begin
        ctrl.inv_b = 1'b1;
        ctrl.op = exec_pkg::ALU_AND;
      end
      isa_pkg::OP_ROLI:
      begin
        ctrl.op = exec_pkg::ALU_ROL;
      end
      isa_pkg::OP_SLLI:
      begin
        ctrl.op = exec_pkg::ALU_SLL;
      end
      isa_pkg::OP_RORI:
      begin
        ctrl.op = exec_pkg::ALU_ROR;
      end
      isa_pkg::OP_SRLI:
      begin
        ctrl.op = exec_pkg::ALU_SRL;
      end
      default:
      begin
        ctrl.op = exec_pkg::ALU_ROL;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/cond_unit.sv */
`default_nettype none

`include "wisc_consts.svh"

module cond_unit (
  input  exec_pkg::issue_t          issue,
  input  logic [`DATA_W-1:0]        alu_result,
  input  logic                      carry_out,
  input  logic                      overflow,
  output exec_pkg::exec_result_t    result
);

  logic is_zero;
  logic is_less;
  logic is_set;
  logic set_bit;

  assign is_zero = (alu_result == '0);
  assign is_less = alu_result[`DATA_W-1] ^ overflow; // Overflow-corrected sign of A - B

  always_comb
  begin
    is_set = 1'b1;
    set_bit = 1'b0;
    result.branch_taken = 1'b0;
    result.halt = 1'b0;
    case (issue.instr.opcode)
      isa_pkg::OP_SEQ:  set_bit = is_zero;
      isa_pkg::OP_SLT:  set_bit = is_less;
      isa_pkg::OP_SLE:  set_bit = is_less | is_zero;
      isa_pkg::OP_SCO:  set_bit = carry_out;
      default:          is_set = 1'b0;
    endcase
    case (issue.instr.opcode)
      isa_pkg::OP_BLTZ: result.branch_taken = issue.operand_a[`DATA_W-1];
      isa_pkg::OP_BGEZ: result.branch_taken = ~issue.operand_a[`DATA_W-1];
      isa_pkg::OP_HALT: result.halt = 1'b1;
      default:          result.halt = 1'b0;
    endcase
    result.word = is_set ? {{(`DATA_W-1){1'b0}}, set_bit} : alu_result;
  end

endmodule

`default_nettype wire

/* src/pipe_reg.sv */
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  payload_t  in_data,
  output logic      out_valid,
  output payload_t  out_data
);

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= in_valid;
  end

  // Payload holds between strobes
  always_ff @(posedge clk)
  begin
    if (in_valid)
      out_data <= in_data;
  end

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`default_nettype none

`include "wisc_consts.svh"

module exec_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  isa_pkg::instr_t           in_instr,
  input  logic [`DATA_W-1:0]        operand_a,
  input  logic [`DATA_W-1:0]        operand_b,
  output logic                      out_valid,
  output exec_pkg::exec_result_t    out_result
);

  exec_pkg::alu_ctrl_t     ctrl_d;
  exec_pkg::issue_t        issue_d;
  exec_pkg::issue_t        issue_q;
  logic                    issue_valid;
  logic [`DATA_W-1:0]      alu_result;
  logic                    alu_carry;
  logic                    alu_ovf;
  exec_pkg::exec_result_t  result_d;

  alu_control i_alu_control (
    .instr (in_instr),
    .ctrl  (ctrl_d)
  );

  assign issue_d = '{instr: in_instr, ctrl: ctrl_d, operand_a: operand_a, operand_b: operand_b};

  pipe_reg #(.payload_t(exec_pkg::issue_t)) i_issue_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (issue_d),
    .out_valid (issue_valid),
    .out_data  (issue_q)
  );

  alu i_alu (
    .a         (issue_q.operand_a),
    .b         (issue_q.operand_b),
    .ctrl      (issue_q.ctrl),
    .result    (alu_result),
    .carry_out (alu_carry),
    .overflow  (alu_ovf)
  );

  cond_unit i_cond_unit (
    .issue      (issue_q),
    .alu_result (alu_result),
    .carry_out  (alu_carry),
    .overflow   (alu_ovf),
    .result     (result_d)
  );

  pipe_reg #(.payload_t(exec_pkg::exec_result_t)) i_result_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (issue_valid),
    .in_data   (result_d),
    .out_valid (out_valid),
    .out_data  (out_result)
  );

endmodule

`default_nettype wire

/* bench/exec_unit_tb.sv */
`default_nettype none

`include "wisc_consts.svh"

module exec_unit_tb;

  typedef logic [`DATA_W-1:0] word_t;

  // Expected output plus the rising edge that accepted the instruction
  typedef struct packed {
    exec_pkg::exec_result_t result;
    logic [31:0]            accept_edge;
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  isa_pkg::instr_t        in_instr;
  word_t                  operand_a;
  word_t                  operand_b;
  logic                   out_valid;
  exec_pkg::exec_result_t out_result;

  expect_t     pending[$];
  logic [31:0] edge_count = '0;

  exec_unit i_exec_unit (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  always #5 clk = ~clk;

  function automatic word_t rotate_left(input word_t value, input int amount);
    word_t r;
    int    i;
    r = value;
    for (i = 0; i < amount; i++)
      r = {r[`DATA_W-2:0], r[`DATA_W-1]};
    return r;
  endfunction

  function automatic word_t rotate_right(input word_t value, input int amount);
    word_t r;
    int    i;
    r = value;
    for (i = 0; i < amount; i++)
      r = {r[0], r[`DATA_W-1:1]};
    return r;
  endfunction

  // Reference behavior of one instruction
  function automatic exec_pkg::exec_result_t model_result(input isa_pkg::instr_t instr,
                                                          input word_t a, input word_t b);
    exec_pkg::exec_result_t r;
    logic [`DATA_W:0]       wide;
    r.word = rotate_left(a, int'(b[3:0])); // HALT and undefined opcodes
    r.branch_taken = 1'b0;
    r.halt = 1'b0;
    wide = {1'b0, a} + {1'b0, b};
    case (instr.opcode)
      isa_pkg::OP_HALT: r.halt = 1'b1;
      isa_pkg::OP_LBI: r.word = b;
      isa_pkg::OP_SLBI: r.word = a | b;
      isa_pkg::OP_ADDI, isa_pkg::OP_ST, isa_pkg::OP_LD, isa_pkg::OP_STU, isa_pkg::OP_BTR:
        r.word = a + b;
      isa_pkg::OP_SUBI: r.word = b - a;
      isa_pkg::OP_XORI: r.word = a ^ b;
      isa_pkg::OP_ANDNI: r.word = a & ~b;
      isa_pkg::OP_RRR:
      begin
        case (instr.funct)
          2'b00: r.word = a + b;
          2'b01: r.word = b - a;
          2'b10: r.word = a ^ b;
          default: r.word = a & ~b;
        endcase
      end
      isa_pkg::OP_ROL:
      begin
        case (instr.funct)
          2'b00: r.word = rotate_left(a, int'(b[3:0]));
          2'b01: r.word = a << b[3:0];
          2'b10: r.word = rotate_right(a, int'(b[3:0]));
          default: r.word = a >> b[3:0];
        endcase
      end
      isa_pkg::OP_ROLI: r.word = rotate_left(a, int'(b[3:0]));
      isa_pkg::OP_SLLI: r.word = a << b[3:0];
      isa_pkg::OP_RORI: r.word = rotate_right(a, int'(b[3:0]));
      isa_pkg::OP_SRLI: r.word = a >> b[3:0];
      isa_pkg::OP_SEQ: r.word = {{(`DATA_W-1){1'b0}}, (a == b)};
      isa_pkg::OP_SLT: r.word = {{(`DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
      isa_pkg::OP_SLE: r.word = {{(`DATA_W-1){1'b0}}, ($signed(a) <= $signed(b))};
      isa_pkg::OP_SCO: r.word = {{(`DATA_W-1){1'b0}}, wide[`DATA_W]};
      isa_pkg::OP_BLTZ:
      begin
        r.word = a - b;
        r.branch_taken = a[`DATA_W-1];
      end
      isa_pkg::OP_BGEZ:
      begin
        r.word = a - b;
        r.branch_taken = ~a[`DATA_W-1];
      end
      default: ;
    endcase
    return r;
  endfunction

  function automatic isa_pkg::instr_t make_instr(input isa_pkg::opcode_e op,
                                                 input logic [1:0] funct);
    isa_pkg::instr_t instr;
    instr.opcode = op;
    instr.funct = funct;
    return instr;
  endfunction

  function automatic word_t rand_word();
    logic [31:0] r;
    r = $urandom();
    return r[`DATA_W-1:0];
  endfunction

  // Random operands with the usual corner values mixed in
  function automatic word_t pick_operand();
    logic [31:0] r;
    r = $urandom();
    case (r[2:0])
      3'd0: return 16'h8000;
      3'd1: return 16'h7fff;
      3'd2: return 16'hffff;
      3'd3: return 16'h0000;
      default: return rand_word();
    endcase
  endfunction

  task automatic stop_on_error();
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_word(input exec_pkg::exec_result_t expected,
                            input exec_pkg::exec_result_t actual);
    if (actual.word !== expected.word)
    begin
      $display("Fail out_result.word: expected %h, got %h", expected.word, actual.word);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input exec_pkg::exec_result_t expected,
                            input exec_pkg::exec_result_t actual);
    if (actual.branch_taken !== expected.branch_taken)
    begin
      $display("Fail out_result.branch_taken: expected %h, got %h",
               expected.branch_taken, actual.branch_taken);
      stop_on_error();
    end
    if (actual.halt !== expected.halt)
    begin
      $display("Fail out_result.halt: expected %h, got %h", expected.halt, actual.halt);
      stop_on_error();
    end
  endtask

  task automatic check_latency(input logic [31:0] expected_edge, input logic [31:0] actual_edge);
    if (actual_edge !== expected_edge)
    begin
      $display("Fail out_valid edge: expected %h, got %h", expected_edge, actual_edge);
      stop_on_error();
    end
  endtask

  always @(posedge clk)
  begin : monitor
    expect_t head;
    edge_count = edge_count + 32'd1;
    if (out_valid === 1'b1)
    begin
      if (pending.size() == 0)
      begin
        $display("out_valid was raised with no instruction in flight");
        stop_on_error();
      end
      else
      begin
        head = pending.pop_front();
        check_latency(head.accept_edge + 32'd2, edge_count);
        check_word(head.result, out_result);
        check_flag(head.result, out_result);
      end
    end
    else if (!rst && out_valid !== 1'b0)
    begin
      $display("out_valid is unknown after reset");
      stop_on_error();
    end
    else if (pending.size() != 0 && edge_count > pending[0].accept_edge + 32'd2)
    begin
      $display("An accepted instruction never produced out_valid");
      stop_on_error();
    end
  end

  task automatic issue(input isa_pkg::instr_t instr, input word_t a, input word_t b);
    expect_t entry;
    @(negedge clk);
    in_valid = 1'b1;
    in_instr = instr;
    operand_a = a;
    operand_b = b;
    entry.result = model_result(instr, a, b);
    entry.accept_edge = edge_count + 32'd1; // Next rising edge
    pending.push_back(entry);
  endtask

  // Operands keep changing while nothing is strobed
  task automatic idle(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      in_valid = 1'b0;
      operand_a = rand_word();
      operand_b = rand_word();
    end
  endtask

  task automatic directed_cases();
    issue(make_instr(isa_pkg::OP_SEQ, 2'b00), 16'h1234, 16'h1234);
    issue(make_instr(isa_pkg::OP_SEQ, 2'b00), 16'h1234, 16'h1235);
    issue(make_instr(isa_pkg::OP_SLT, 2'b00), 16'h8000, 16'h7fff);
    issue(make_instr(isa_pkg::OP_SLT, 2'b00), 16'h7fff, 16'h8000);
    issue(make_instr(isa_pkg::OP_SLT, 2'b00), 16'h8000, 16'h8000);
    issue(make_instr(isa_pkg::OP_SLE, 2'b00), 16'h8000, 16'h8000);
    issue(make_instr(isa_pkg::OP_SLE, 2'b00), 16'h0001, 16'h8001);
    idle(2);
    issue(make_instr(isa_pkg::OP_SCO, 2'b00), 16'hffff, 16'h0001);
    issue(make_instr(isa_pkg::OP_SCO, 2'b00), 16'h7fff, 16'h7fff);
    issue(make_instr(isa_pkg::OP_BLTZ, 2'b00), 16'h8000, 16'h0001);
    issue(make_instr(isa_pkg::OP_BLTZ, 2'b00), 16'h0000, 16'h0001);
    issue(make_instr(isa_pkg::OP_BGEZ, 2'b00), 16'h7fff, 16'hffff);
    issue(make_instr(isa_pkg::OP_BGEZ, 2'b00), 16'hffff, 16'h7fff);
    issue(make_instr(isa_pkg::OP_HALT, 2'b00), 16'h8001, 16'h0003);
    idle(3);
  endtask

  initial
  begin : stimulus
    int          i;
    int          k;
    logic [31:0] r;
    int          wait_cycles;
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    operand_a = '0;
    operand_b = '0;
    void'($urandom(32'h55dda848));
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle(4);

    issue(make_instr(isa_pkg::OP_RRR, 2'b00), 16'h0102, 16'h0304);
    idle(5);
    directed_cases();

    // Every shift amount for the register and immediate shift forms
    for (i = 0; i < 16; i++)
    begin
      for (k = 0; k < 4; k++)
        issue(make_instr(isa_pkg::OP_ROL, k[1:0]), rand_word(), {rand_word() & 16'hfff0} | i[15:0]);
      issue(make_instr(isa_pkg::OP_ROLI, 2'b00), rand_word(), {12'h000, i[3:0]});
      issue(make_instr(isa_pkg::OP_SLLI, 2'b00), rand_word(), {12'h000, i[3:0]});
      issue(make_instr(isa_pkg::OP_RORI, 2'b00), rand_word(), {12'h000, i[3:0]});
      issue(make_instr(isa_pkg::OP_SRLI, 2'b00), rand_word(), {12'h000, i[3:0]});
    end
    idle(2);

    // Sweep of all opcodes and function fields including undefined ones
    for (i = 0; i < 32; i++)
      for (k = 0; k < 4; k++)
        issue(make_instr(isa_pkg::opcode_e'(i[4:0]), k[1:0]), pick_operand(), pick_operand());
    idle(1);

    for (i = 0; i < 600; i++)
    begin
      r = $urandom();
      issue(make_instr(isa_pkg::opcode_e'(r[4:0]), r[6:5]), pick_operand(), pick_operand());
      if (r[9:8] == 2'b00)
        idle(int'(r[11:10]) + 1); // Random gap
    end
    idle(1);

    wait_cycles = 0;
    while (pending.size() != 0 && wait_cycles < 20)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (pending.size() == 0)
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
    begin
      $display("Outputs still missing when the drain timed out");
      $display("SIMULATION FAILED");
      $fatal(1, "Drain timeout");
    end
  end

endmodule

`default_nettype wire

/* exec_unit.f */
+incdir+common
common/isa_pkg.sv
common/exec_pkg.sv
alu/shifter.sv
alu/alu.sv
src/alu_control.sv
src/cond_unit.sv
src/pipe_reg.sv
src/exec_unit.sv
bench/exec_unit_tb.sv

/* Makefile */
TOP := exec_unit_tb
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a listed source, the header or the file list changes
$(BIN): exec_unit.f $(shell grep -v '^+' exec_unit.f) common/wisc_consts.svh
	verilator --binary --timing -j 0 --top-module $(TOP) -f exec_unit.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
